// File: source/rbe_defs.svh
//////////////////////////////////////////////////
// register map, field positions and fixed
// constants of the convolution controller
// include wherever an address or constant is used
//////////////////////////////////////////////////

`ifndef RBE_DEFS_SVH
`define RBE_DEFS_SVH

// register word addresses
`define RBE_REG_TRIGGER   0
`define RBE_REG_STATUS    1
`define RBE_REG_CHANNELS  2
`define RBE_REG_IMG       3
`define RBE_REG_QUANT_FS  4
`define RBE_REG_STREAM    5
`define RBE_REG_PATCH_H   6
`define RBE_N_REGS        8

// field positions, all stored as value minus one
`define RBE_F_KIN   31:16
`define RBE_F_KOUT  15:0
`define RBE_F_IW    31:16
`define RBE_F_FS    23:16
`define RBE_F_QW    15:8
`define RBE_F_QA    7:0

// engine geometry
`define RBE_TP               4
`define RBE_PATCH_MIN        3
`define RBE_CH_PER_TILE_LOG2 5
`define RBE_QA_PER_TILE_LOG2 2

`endif

// File: source/rbe_pkg.sv
//////////////////////////////////////////////////
// shared types of the convolution controller
// ports name these with rbe_pkg:: and bodies
// import the package when they need it
//////////////////////////////////////////////////

`include "rbe_defs.svh"

package rbe_pkg;

  // host register port
  typedef logic [$clog2(`RBE_N_REGS)-1:0] reg_addr_t;
  typedef logic [31:0]                    reg_data_t;

  // decoded layer settings
  typedef logic [15:0] feat_cnt_t;
  typedef logic [15:0] spatial_cnt_t;
  typedef logic [7:0]  quant_cnt_t;
  typedef logic [11:0] tile_cnt_t;
  typedef logic [31:0] size_t;

  // job sequencing
  typedef enum logic [2:0] {
    IDLE, PRECOMP, ISSUE, WAIT_ENGINE, ADVANCE
  } ctrl_state_t;

endpackage

// File: source/rbe_seq_mult.sv
//////////////////////////////////////////////////
// shift-add sequential multiplier
// pulse start_i with the operands applied, the
// product is valid B_WIDTH+1 cycles later
//////////////////////////////////////////////////

`timescale 1ns/1ns

module rbe_seq_mult #(
  parameter int unsigned A_WIDTH = 16,
  parameter int unsigned B_WIDTH = 16
) (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       start_i,
  input  logic [A_WIDTH-1:0]         a_i,
  input  logic [B_WIDTH-1:0]         b_i,
  output logic                       valid_o,
  output logic [A_WIDTH+B_WIDTH-1:0] prod_o
);

  localparam int unsigned CNT_W = $clog2(B_WIDTH + 1);

  logic [CNT_W-1:0]           cnt_q;
  logic                       running_q;
  logic [A_WIDTH+B_WIDTH-1:0] mcand_q;
  logic [B_WIDTH-1:0]         mplier_q;
  logic [A_WIDTH+B_WIDTH-1:0] acc_q;

  // bit counter and valid flag
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q     <= '0;
      running_q <= 1'b0;
      valid_o   <= 1'b0;
    end else if (start_i) begin
      cnt_q     <= '0;
      running_q <= 1'b1;
      valid_o   <= 1'b0;
    end else if (running_q) begin
      cnt_q <= cnt_q + 1'b1;
      if (cnt_q == CNT_W'(B_WIDTH - 1)) begin
        running_q <= 1'b0;
        valid_o   <= 1'b1;
      end
    end
  end

  // one multiplier bit per cycle, lsb first
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mcand_q  <= '0;
      mplier_q <= '0;
      acc_q    <= '0;
    end else if (start_i) begin
      mcand_q  <= {{B_WIDTH{1'b0}}, a_i};
      mplier_q <= b_i;
      acc_q    <= '0;
    end else if (running_q) begin
      if (mplier_q[0]) begin
        acc_q <= acc_q + mcand_q;
      end
      mcand_q  <= mcand_q << 1;
      mplier_q <= mplier_q >> 1;
    end
  end

  assign prod_o = acc_q;

endmodule

// File: source/rbe_cfg_regs.sv
//////////////////////////////////////////////////
// host register file of the controller
// holds the layer settings, decodes each field,
// raises start on a trigger write while idle and
// keeps the derived sizes for readback
//////////////////////////////////////////////////

`timescale 1ns/1ns

`include "rbe_defs.svh"

module rbe_cfg_regs (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 reg_we_i,
  input  rbe_pkg::reg_addr_t   reg_addr_i,
  input  rbe_pkg::reg_data_t   reg_wdata_i,
  input  logic                 busy_i,
  input  logic                 capture_i,
  input  rbe_pkg::size_t       stream_size_i,
  input  rbe_pkg::size_t       patch_h_i,
  output rbe_pkg::reg_data_t   reg_rdata_o,
  output logic                 start_o,
  output rbe_pkg::feat_cnt_t   kin_o,
  output rbe_pkg::feat_cnt_t   kout_o,
  output rbe_pkg::spatial_cnt_t iw_o,
  output rbe_pkg::quant_cnt_t  fs_o,
  output rbe_pkg::quant_cnt_t  qw_o,
  output rbe_pkg::quant_cnt_t  qa_o
);
  import rbe_pkg::*;

  reg_data_t channels_q;
  reg_data_t img_q;
  reg_data_t quant_q;
  size_t     stream_q;
  size_t     patch_q;
  logic      start_q;
  logic      wr_ok;

  // start_q covers the cycle before busy rises
  assign wr_ok = reg_we_i & ~(busy_i | start_q);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      channels_q <= '0;
      img_q      <= '0;
      quant_q    <= '0;
      stream_q   <= '0;
      patch_q    <= '0;
      start_q    <= 1'b0;
    end else begin
      start_q <= wr_ok && (reg_addr_i == reg_addr_t'(`RBE_REG_TRIGGER));
      if (wr_ok) begin
        case (reg_addr_i)
          reg_addr_t'(`RBE_REG_CHANNELS): channels_q <= reg_wdata_i;
          reg_addr_t'(`RBE_REG_IMG):      img_q      <= reg_wdata_i;
          reg_addr_t'(`RBE_REG_QUANT_FS): quant_q    <= reg_wdata_i;
          default: ;
        endcase
      end
      // results land once the multipliers are done
      if (capture_i) begin
        stream_q <= stream_size_i;
        patch_q  <= patch_h_i;
      end
    end
  end

  assign start_o = start_q;

  // field decode
  assign kin_o  = channels_q[`RBE_F_KIN] + 1'b1;
  assign kout_o = channels_q[`RBE_F_KOUT] + 1'b1;
  assign iw_o   = img_q[`RBE_F_IW] + 1'b1;
  assign fs_o   = quant_q[`RBE_F_FS] + 1'b1;
  assign qw_o   = quant_q[`RBE_F_QW] + 1'b1;
  assign qa_o   = quant_q[`RBE_F_QA] + 1'b1;

  // readback mux
  always_comb begin
    case (reg_addr_i)
      reg_addr_t'(`RBE_REG_STATUS):   reg_rdata_o = {31'b0, busy_i};
      reg_addr_t'(`RBE_REG_CHANNELS): reg_rdata_o = channels_q;
      reg_addr_t'(`RBE_REG_IMG):      reg_rdata_o = img_q;
      reg_addr_t'(`RBE_REG_QUANT_FS): reg_rdata_o = quant_q;
      reg_addr_t'(`RBE_REG_STREAM):   reg_rdata_o = stream_q;
      reg_addr_t'(`RBE_REG_PATCH_H):  reg_rdata_o = patch_q;
      default:                        reg_rdata_o = '0;
    endcase
  end

endmodule

// File: source/rbe_cfg_derive.sv
//////////////////////////////////////////////////
// derived job sizes
// tile counts are combinational, the stream size
// and patch height come from two sequential
// multipliers started together by mult_start_i
//////////////////////////////////////////////////

`timescale 1ns/1ns

`include "rbe_defs.svh"

module rbe_cfg_derive (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  mult_start_i,
  input  rbe_pkg::feat_cnt_t    kin_i,
  input  rbe_pkg::feat_cnt_t    kout_i,
  input  rbe_pkg::spatial_cnt_t iw_i,
  input  rbe_pkg::quant_cnt_t   fs_i,
  input  rbe_pkg::quant_cnt_t   qw_i,
  input  rbe_pkg::quant_cnt_t   qa_i,
  output rbe_pkg::tile_cnt_t    tiles_k_in_o,
  output rbe_pkg::tile_cnt_t    tiles_k_out_o,
  output logic                  mult_valid_o,
  output rbe_pkg::size_t        stream_size_o,
  output rbe_pkg::size_t        patch_h_o
);
  import rbe_pkg::*;

  feat_cnt_t   kin_m1;
  feat_cnt_t   kout_m1;
  quant_cnt_t  qa_m1;
  tile_cnt_t   tiles_qa;
  logic [15:0] stream_a;
  logic [15:0] stream_b;
  logic [23:0] patch_b;
  logic [31:0] stream_prod;
  logic [39:0] patch_prod;
  logic        stream_valid;
  logic        patch_valid;

  ////////////////////////////////////////////////////
  // tile counts
  ////////////////////////////////////////////////////
  assign kin_m1        = kin_i - 1'b1;
  assign kout_m1       = kout_i - 1'b1;
  assign qa_m1         = qa_i - 1'b1;
  assign tiles_k_in_o  = tile_cnt_t'(kin_m1 >> `RBE_CH_PER_TILE_LOG2) + 1'b1;
  assign tiles_k_out_o = tile_cnt_t'(kout_m1 >> `RBE_CH_PER_TILE_LOG2) + 1'b1;
  assign tiles_qa      = tile_cnt_t'(qa_m1 >> `RBE_QA_PER_TILE_LOG2) + 1'b1;

  ////////////////////////////////////////////////////
  // multiplier operands
  ////////////////////////////////////////////////////
  // 1x1 filter: qw bytes times (TP+2)
  assign stream_a = (fs_i == 8'd1) ? (16'(qw_i) << 2)
                                   : 16'(qw_i) * 16'(`RBE_TP) + 16'd2;
  assign stream_b = (fs_i == 8'd1) ? 16'(`RBE_TP + 2) : 16'(fs_i) * 16'(fs_i);
  assign patch_b  = 24'(tiles_k_in_o) * 24'(tiles_qa);

  rbe_seq_mult #(
    .A_WIDTH ( 16 ),
    .B_WIDTH ( 16 )
  ) i_stream_mult (
    .clk_i   ( clk_i        ),
    .rst_n_i ( rst_n_i      ),
    .start_i ( mult_start_i ),
    .a_i     ( stream_a     ),
    .b_i     ( stream_b     ),
    .valid_o ( stream_valid ),
    .prod_o  ( stream_prod  )
  );

  rbe_seq_mult #(
    .A_WIDTH ( 16 ),
    .B_WIDTH ( 24 )
  ) i_patch_mult (
    .clk_i   ( clk_i        ),
    .rst_n_i ( rst_n_i      ),
    .start_i ( mult_start_i ),
    .a_i     ( iw_i         ),
    .b_i     ( patch_b      ),
    .valid_o ( patch_valid  ),
    .prod_o  ( patch_prod   )
  );

  // the 24-bit multiplier finishes last
  assign mult_valid_o  = stream_valid & patch_valid;
  assign stream_size_o = stream_prod;
  // constant scale TP * PATCH_MIN * 4 bytes
  assign patch_h_o     = patch_prod[31:0] * 32'(`RBE_TP * `RBE_PATCH_MIN * 4);

endmodule

// File: source/rbe_tile_loop.sv
//////////////////////////////////////////////////
// nested channel tile counters
// input tile index is the inner loop and wraps
// into the output tile index; last_o flags the
// final pair of the job
//////////////////////////////////////////////////

`timescale 1ns/1ns

module rbe_tile_loop (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               clear_i,
  input  logic               step_i,
  input  rbe_pkg::tile_cnt_t tiles_k_in_i,
  input  rbe_pkg::tile_cnt_t tiles_k_out_i,
  output rbe_pkg::tile_cnt_t k_in_o,
  output rbe_pkg::tile_cnt_t k_out_o,
  output logic               last_o
);
  import rbe_pkg::*;

  tile_cnt_t k_in_q;
  tile_cnt_t k_out_q;
  logic      in_wrap;
  logic      out_wrap;

  assign in_wrap  = (k_in_q == tiles_k_in_i - 1'b1);
  assign out_wrap = (k_out_q == tiles_k_out_i - 1'b1);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      k_in_q  <= '0;
      k_out_q <= '0;
    end else if (clear_i) begin
      k_in_q  <= '0;
      k_out_q <= '0;
    end else if (step_i) begin
      if (in_wrap) begin
        k_in_q  <= '0;
        k_out_q <= k_out_q + 1'b1;
      end else begin
        k_in_q <= k_in_q + 1'b1;
      end
    end
  end

  assign k_in_o  = k_in_q;
  assign k_out_o = k_out_q;
  assign last_o  = in_wrap & out_wrap;

endmodule

// File: source/rbe_ctrl_fsm.sv
//////////////////////////////////////////////////
// job sequencing FSM
// starts the multipliers, then issues one engine
// start per tile pair and waits for its done;
// evt_done_o closes the job
//////////////////////////////////////////////////

`timescale 1ns/1ns

module rbe_ctrl_fsm (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic start_i,
  input  logic mult_valid_i,
  input  logic engine_done_i,
  input  logic loop_last_i,
  output logic busy_o,
  output logic mult_start_o,
  output logic products_done_o,
  output logic loop_clear_o,
  output logic loop_step_o,
  output logic engine_start_o,
  output logic evt_done_o
);
  import rbe_pkg::*;

  ctrl_state_t state_q;
  ctrl_state_t state_d;

  ////////////////////////////////////////////////////
  // next state
  ////////////////////////////////////////////////////
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:        if (start_i) state_d = PRECOMP;
      PRECOMP:     if (mult_valid_i) state_d = ISSUE;
      ISSUE:       state_d = WAIT_ENGINE;
      WAIT_ENGINE: if (engine_done_i) state_d = ADVANCE;
      ADVANCE:     state_d = loop_last_i ? IDLE : ISSUE;
      default:     state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  ////////////////////////////////////////////////////
  // outputs
  ////////////////////////////////////////////////////
  // multipliers and loop restart on the edge into PRECOMP,
  // so a stale valid from the last job is already cleared
  assign mult_start_o    = (state_q == IDLE) & start_i;
  assign loop_clear_o    = (state_q == IDLE) & start_i;
  assign products_done_o = (state_q == PRECOMP) & mult_valid_i;
  assign engine_start_o  = (state_q == ISSUE);
  assign loop_step_o     = (state_q == ADVANCE) & ~loop_last_i;
  assign evt_done_o      = (state_q == ADVANCE) & loop_last_i;

  // busy falls together with the completion event
  assign busy_o = (state_q != IDLE) & ~evt_done_o;

endmodule

// File: source/rbe_ctrl_top.sv
//////////////////////////////////////////////////
// convolution controller top level
// host register port in, engine start/done
// handshake and tile indices out
//////////////////////////////////////////////////

`timescale 1ns/1ns

module rbe_ctrl_top (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  reg_we_i,
  input  rbe_pkg::reg_addr_t    reg_addr_i,
  input  rbe_pkg::reg_data_t    reg_wdata_i,
  output rbe_pkg::reg_data_t    reg_rdata_o,
  input  logic                  engine_done_i,
  output logic                  engine_start_o,
  output rbe_pkg::tile_cnt_t    tile_k_in_o,
  output rbe_pkg::tile_cnt_t    tile_k_out_o,
  output logic                  busy_o,
  output logic                  evt_done_o
);
  import rbe_pkg::*;

  // decoded settings
  feat_cnt_t    kin, kout;
  spatial_cnt_t iw;
  quant_cnt_t   fs, qw, qa;
  tile_cnt_t    tiles_k_in, tiles_k_out;
  size_t        stream_size, patch_h;
  // control
  logic start, mult_start, mult_valid, products_done;
  logic loop_clear, loop_step, loop_last;

  rbe_cfg_regs i_cfg_regs (
    .clk_i, .rst_n_i, .reg_we_i, .reg_addr_i, .reg_wdata_i, .reg_rdata_o,
    .busy_i        ( busy_o        ),
    .capture_i     ( products_done ),
    .stream_size_i ( stream_size   ),
    .patch_h_i     ( patch_h       ),
    .start_o       ( start         ),
    .kin_o ( kin ), .kout_o ( kout ), .iw_o ( iw ),
    .fs_o  ( fs  ), .qw_o   ( qw   ), .qa_o ( qa )
  );

  rbe_cfg_derive i_cfg_derive (
    .clk_i, .rst_n_i,
    .mult_start_i  ( mult_start  ),
    .kin_i ( kin ), .kout_i ( kout ), .iw_i ( iw ),
    .fs_i  ( fs  ), .qw_i   ( qw   ), .qa_i ( qa ),
    .tiles_k_in_o  ( tiles_k_in  ),
    .tiles_k_out_o ( tiles_k_out ),
    .mult_valid_o  ( mult_valid  ),
    .stream_size_o ( stream_size ),
    .patch_h_o     ( patch_h     )
  );

  rbe_tile_loop i_tile_loop (
    .clk_i, .rst_n_i,
    .clear_i       ( loop_clear   ),
    .step_i        ( loop_step    ),
    .tiles_k_in_i  ( tiles_k_in   ),
    .tiles_k_out_i ( tiles_k_out  ),
    .k_in_o        ( tile_k_in_o  ),
    .k_out_o       ( tile_k_out_o ),
    .last_o        ( loop_last    )
  );

  rbe_ctrl_fsm i_ctrl_fsm (
    .clk_i, .rst_n_i, .engine_done_i, .busy_o, .engine_start_o, .evt_done_o,
    .start_i         ( start         ),
    .mult_valid_i    ( mult_valid    ),
    .loop_last_i     ( loop_last     ),
    .mult_start_o    ( mult_start    ),
    .products_done_o ( products_done ),
    .loop_clear_o    ( loop_clear    ),
    .loop_step_o     ( loop_step     )
  );

endmodule

// File: verification/rbe_ctrl_tb.sv
//////////////////////////////////////////////////
// directed testbench of the convolution controller
// programs jobs through the host port, answers
// engine starts with random-delay done pulses and
// checks results, tile order and busy handling
//////////////////////////////////////////////////

`timescale 1ns/1ns

`include "rbe_defs.svh"

module rbe_ctrl_tb;
  import rbe_pkg::*;

  localparam int unsigned WAIT_LIMIT = 5000;

  logic      clk;
  logic      rst_n;
  logic      reg_we;
  reg_addr_t reg_addr;
  reg_data_t reg_wdata;
  reg_data_t reg_rdata;
  logic      engine_done;
  logic      engine_start;
  tile_cnt_t tile_k_in;
  tile_cnt_t tile_k_out;
  logic      busy;
  logic      evt_done;

  integer    seed;
  int        err_cnt;
  int        chk_cnt;
  int        evt_cnt;
  tile_cnt_t seen_k_in[$];
  tile_cnt_t seen_k_out[$];

  rbe_ctrl_top dut (
    .clk_i          ( clk          ),
    .rst_n_i        ( rst_n        ),
    .reg_we_i       ( reg_we       ),
    .reg_addr_i     ( reg_addr     ),
    .reg_wdata_i    ( reg_wdata    ),
    .reg_rdata_o    ( reg_rdata    ),
    .engine_done_i  ( engine_done  ),
    .engine_start_o ( engine_start ),
    .tile_k_in_o    ( tile_k_in    ),
    .tile_k_out_o   ( tile_k_out   ),
    .busy_o         ( busy         ),
    .evt_done_o     ( evt_done     )
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    if (evt_done === 1'b1) evt_cnt++;
  end

  ////////////////////////////////////////////////////
  // reference rules
  ////////////////////////////////////////////////////
  function automatic int unsigned tiles(int unsigned n, int unsigned per_log2);
    return ((n - 1) >> per_log2) + 1;
  endfunction

  function automatic int unsigned exp_stream(int unsigned fs, int unsigned qw);
    if (fs == 1) return qw * 4 * (`RBE_TP + 2);
    return (qw * `RBE_TP + 2) * fs * fs;
  endfunction

  function automatic int unsigned exp_patch(int unsigned iw, int unsigned kin,
                                            int unsigned qa);
    return iw * tiles(kin, `RBE_CH_PER_TILE_LOG2) * tiles(qa, `RBE_QA_PER_TILE_LOG2)
           * `RBE_TP * `RBE_PATCH_MIN * 4;
  endfunction

  ////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////
  task automatic check_value(string what, logic [31:0] got, logic [31:0] exp);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("[ERROR] %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic stop_on_timeout(string what);
    $display("timeout: no %s within %0d cycles", what, WAIT_LIMIT);
    $display("** FAIL **");
    $finish;
  endtask

  task automatic reg_write(int unsigned addr, reg_data_t data);
    @(posedge clk);
    reg_we    <= 1'b1;
    reg_addr  <= reg_addr_t'(addr);
    reg_wdata <= data;
    @(posedge clk);
    reg_we    <= 1'b0;
  endtask

  task automatic reg_read(int unsigned addr, output reg_data_t data);
    @(posedge clk);
    reg_addr <= reg_addr_t'(addr);
    @(negedge clk);
    data = reg_rdata;
  endtask

  task automatic wait_busy_level(logic level);
    int cycles;
    cycles = 0;
    while (busy !== level && cycles < WAIT_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    if (busy !== level) begin
      stop_on_timeout("change of the busy level");
    end
  endtask

  task automatic wait_job_done();
    int   cycles;
    logic seen;
    cycles = 0;
    seen   = 1'b0;
    while (!seen && cycles < WAIT_LIMIT) begin
      @(posedge clk);
      seen = (evt_done === 1'b1);
      cycles++;
    end
    if (seen) begin
      // busy falls in the cycle of the completion event
      check_value("busy at completion", busy, 0);
    end else begin
      stop_on_timeout("completion event");
    end
  endtask

  // engine model, one tile in flight
  task automatic respond_engine();
    int        delay;
    tile_cnt_t k_in;
    tile_cnt_t k_out;
    forever begin
      @(posedge clk);
      if (engine_start === 1'b1) begin
        k_in  = tile_k_in;
        k_out = tile_k_out;
        seen_k_in.push_back(k_in);
        seen_k_out.push_back(k_out);
        delay = {$random(seed)} % 8;
        repeat (delay) begin
          @(posedge clk);
          check_value("held input tile index", tile_k_in, k_in);
          check_value("held output tile index", tile_k_out, k_out);
        end
        engine_done <= 1'b1;
        @(posedge clk);
        engine_done <= 1'b0;
      end
    end
  endtask

  task automatic configure(int unsigned kin, int unsigned kout, int unsigned iw,
                           int unsigned fs, int unsigned qw, int unsigned qa);
    reg_write(`RBE_REG_CHANNELS, ((kin - 1) << 16) | (kout - 1));
    reg_write(`RBE_REG_IMG, (iw - 1) << 16);
    reg_write(`RBE_REG_QUANT_FS, ((fs - 1) << 16) | ((qw - 1) << 8) | (qa - 1));
    seen_k_in.delete();
    seen_k_out.delete();
  endtask

  task automatic check_job(int unsigned kin, int unsigned kout, int unsigned iw,
                           int unsigned fs, int unsigned qw, int unsigned qa,
                           int evt_before);
    reg_data_t   rd;
    int unsigned tin;
    int unsigned tout;
    tin  = tiles(kin, `RBE_CH_PER_TILE_LOG2);
    tout = tiles(kout, `RBE_CH_PER_TILE_LOG2);
    reg_read(`RBE_REG_STREAM, rd);
    check_value("STREAM", rd, exp_stream(fs, qw));
    reg_read(`RBE_REG_PATCH_H, rd);
    check_value("PATCH_H", rd, exp_patch(iw, kin, qa));
    reg_read(`RBE_REG_STATUS, rd);
    check_value("STATUS after job", rd, 0);
    reg_read(`RBE_REG_CHANNELS, rd);
    check_value("CHANNELS", rd, ((kin - 1) << 16) | (kout - 1));
    reg_read(`RBE_REG_IMG, rd);
    check_value("IMG", rd, (iw - 1) << 16);
    reg_read(`RBE_REG_QUANT_FS, rd);
    check_value("QUANT_FS", rd, ((fs - 1) << 16) | ((qw - 1) << 8) | (qa - 1));
    check_value("completion events", evt_cnt - evt_before, 1);
    check_value("engine starts", seen_k_in.size(), tin * tout);
    // input tile inner, output tile outer
    for (int n = 0; n < seen_k_in.size(); n++) begin
      check_value("input tile index", seen_k_in[n], n % tin);
      check_value("output tile index", seen_k_out[n], n / tin);
    end
  endtask

  task automatic run_job(int unsigned kin, int unsigned kout, int unsigned iw,
                         int unsigned fs, int unsigned qw, int unsigned qa);
    int evt_before;
    configure(kin, kout, iw, fs, qw, qa);
    evt_before = evt_cnt;
    reg_write(`RBE_REG_TRIGGER, 1);
    wait_job_done();
    check_job(kin, kout, iw, fs, qw, qa, evt_before);
  endtask

  ////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////
  task automatic test_reset_state();
    reg_data_t rd;
    reg_read(`RBE_REG_STATUS, rd);
    check_value("STATUS after reset", rd, 0);
    reg_read(`RBE_REG_STREAM, rd);
    check_value("STREAM after reset", rd, 0);
    reg_read(`RBE_REG_PATCH_H, rd);
    check_value("PATCH_H after reset", rd, 0);
    repeat (8) @(posedge clk);
    check_value("engine starts after reset", seen_k_in.size(), 0);
    check_value("events after reset", evt_cnt, 0);
  endtask

  task automatic test_busy_writes();
    int        evt_before;
    reg_data_t rd;
    configure(33, 65, 7, 3, 1, 5);
    evt_before = evt_cnt;
    reg_write(`RBE_REG_TRIGGER, 1);
    wait_busy_level(1'b1);
    reg_read(`RBE_REG_STATUS, rd);
    check_value("STATUS while busy", rd, 1);
    reg_write(`RBE_REG_CHANNELS, 32'h00ff_00ff);
    reg_write(`RBE_REG_IMG, 32'h0040_0000);
    reg_write(`RBE_REG_QUANT_FS, 32'h0000_0303);
    reg_write(`RBE_REG_TRIGGER, 1);
    wait_job_done();
    check_job(33, 65, 7, 3, 1, 5, evt_before);
    // the ignored trigger must not start a second job
    repeat (40) @(posedge clk);
    check_value("events after idle", evt_cnt - evt_before, 1);
    check_value("engine starts after idle", seen_k_in.size(), 6);
    reg_read(`RBE_REG_STATUS, rd);
    check_value("STATUS after idle", rd, 0);
  endtask

  initial begin
    respond_engine();
  end

  initial begin
    seed        = 32'h3a9613a9;
    err_cnt     = 0;
    chk_cnt     = 0;
    evt_cnt     = 0;
    clk         = 1'b0;
    rst_n       = 1'b0;
    reg_we      = 1'b0;
    reg_addr    = '0;
    reg_wdata   = '0;
    engine_done = 1'b0;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    test_reset_state();
    run_job(64, 40, 10, 1, 2, 8);
    run_job(100, 70, 20, 3, 4, 3);
    test_busy_writes();
    $display("checks: %0d, errors: %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// File: tb.f
+incdir+source
source/rbe_pkg.sv
source/rbe_seq_mult.sv
source/rbe_cfg_regs.sv
source/rbe_cfg_derive.sv
source/rbe_tile_loop.sv
source/rbe_ctrl_fsm.sv
source/rbe_ctrl_top.sv
verification/rbe_ctrl_tb.sv

// File: Bender.yml
package:
  name: rbe_ctrl

export_include_dirs:
  - source

sources:
  - files:
      - source/rbe_pkg.sv
      - source/rbe_seq_mult.sv
      - source/rbe_cfg_regs.sv
      - source/rbe_cfg_derive.sv
      - source/rbe_tile_loop.sv
      - source/rbe_ctrl_fsm.sv
      - source/rbe_ctrl_top.sv
  - target: test
    files:
      - verification/rbe_ctrl_tb.sv
